// ==== source/smu_ctl_settings.svh ====
////////////////////////////////////////////////////////////////////////////
// smu control fpga settings
// frame length, register sizes and synchronizer depth
////////////////////////////////////////////////////////////////////////////

`ifndef SMU_CTL_SETTINGS_SVH
`define SMU_CTL_SETTINGS_SVH

// host spi frame, addr byte then clear and set nibbles
`define SMU_FRAME_BITS 16

// each control register is one nibble
`define SMU_REG_BITS 4

// led, mux, dac, rails, dac_ref_mux, adc, clamp1, clamp2, rails_oe
`define SMU_NUM_REGS 9

// adc03, dac, flash, adc02
`define SMU_NUM_PERIPH 4

// flops between the spi pins and the clk domain
`define SMU_SYNC_STAGES 2

`endif

// ==== source/smu_spi_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// spi frame types
// one frame word, seen raw while shifting and as fields once latched
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "smu_ctl_settings.svh"

package smu_spi_pkg;

  // msb first on the wire, so addr arrives first
  typedef struct packed {
    logic [7:0] addr;
    // high nibble clears
    logic [3:0] clear;
    // low nibble sets
    logic [3:0] set;
  } spi_fields_t;

  // same 16 bits, shift view and decode view
  typedef union packed {
    logic [`SMU_FRAME_BITS-1:0] raw;
    spi_fields_t                fields;
  } spi_frame_u;

  // writing here reloads every register
  localparam logic [7:0] soft_reset_addr = 8'd11;

endpackage

`default_nettype wire

// ==== source/smu_ctl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// control register map
// addresses, reset values and the board pin bundle
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "smu_ctl_settings.svh"

package smu_ctl_pkg;

  typedef logic [`SMU_REG_BITS-1:0] ctl_reg_t;
  typedef ctl_reg_t [`SMU_NUM_REGS-1:0] ctl_regs_t;

  ////////////////////////////////////////////////////////////////////////
  // slice index of each register

  localparam int led_index         = 0;
  localparam int mux_index         = 1;
  localparam int dac_index         = 2;
  localparam int rails_index       = 3;
  localparam int dac_ref_mux_index = 4;
  localparam int adc_index         = 5;
  localparam int clamp1_index      = 6;
  localparam int clamp2_index      = 7;
  localparam int rails_oe_index    = 8;

  // spi address per slice, 11 is taken by soft reset
  localparam logic [7:0] reg_addr_table [`SMU_NUM_REGS] = '{
    8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd16, 8'd24
  };

  // dg444 switches and clamps are active low, so they idle high
  // rails_oe active low too, rails stay off until the host is ready
  localparam ctl_reg_t reg_reset_table [`SMU_NUM_REGS] = '{
    4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b1111,
    4'b0000, 4'b1111, 4'b1111, 4'b0001
  };

  ////////////////////////////////////////////////////////////////////////
  // board pins

  typedef struct packed {
    logic ldac;
    logic uni_bip_a;
    logic uni_bip_b;
    logic rst;
  } dac_pins_t;

  // adc02 mode straps and reset
  typedef struct packed {
    logic m0;
    logic m1;
    logic m2;
    logic rst;
  } adc_pins_t;

  typedef struct packed {
    logic [1:0] led;
    dac_pins_t  dac;
    logic [3:0] rails;
    logic       rails_oe;
    logic [1:0] dac_ref_mux;
    adc_pins_t  adc;
    logic [3:0] clamp1;
    logic [3:0] clamp2;
  } smu_pins_t;

endpackage

`default_nettype wire

// ==== source/spi_frame_rx.sv ====
////////////////////////////////////////////////////////////////////////////
// spi frame receiver
// oversamples the host spi in clk, shifts frames, strobes commit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "smu_ctl_settings.svh"

module spi_frame_rx (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    special_n,
  input  logic                    mosi,
  output smu_spi_pkg::spi_frame_u frame,
  output logic                    commit,
  output logic                    soft_reset
);

  import smu_spi_pkg::*;

  // one spare count bit so long frames saturate above 16
  localparam int cnt_bits = $clog2(`SMU_FRAME_BITS) + 2;

  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic special_n;
    logic mosi;
  } spi_in_t;

  // bus idle, deselected with clock low
  localparam spi_in_t idle_in = '{sclk: 1'b0, cs_n: 1'b1, special_n: 1'b1, mosi: 1'b0};

  // last stage is only kept for edge detect
  spi_in_t               sync_q [`SMU_SYNC_STAGES+1];
  spi_in_t               pin_in;
  spi_in_t               now_in;
  spi_in_t               last_in;
  logic                  sclk_rise;
  logic                  cs_rise;
  logic                  frame_ok;
  logic [cnt_bits-1:0]   bit_count;
  spi_frame_u            shift_q;

  assign pin_in = '{sclk: sclk, cs_n: cs_n, special_n: special_n, mosi: mosi};

  ////////////////////////////////////////////////////////////////////////
  // synchronizer

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i <= `SMU_SYNC_STAGES; i++)
        sync_q[i] <= idle_in;
    end
    else
    begin
      sync_q[0] <= pin_in;
      for (int i = 1; i <= `SMU_SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  assign now_in  = sync_q[`SMU_SYNC_STAGES-1];
  assign last_in = sync_q[`SMU_SYNC_STAGES];

  assign sclk_rise = now_in.sclk & ~last_in.sclk;
  // end of frame is cs_n going back high
  assign cs_rise   = now_in.cs_n & ~last_in.cs_n;

  ////////////////////////////////////////////////////////////////////////
  // shift and count

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      shift_q   <= '0;
      bit_count <= '0;
    end
    else if (now_in.cs_n)
      bit_count <= '0;
    else if (sclk_rise && !now_in.special_n)
    begin
      // mosi into lsb, earlier bits move toward msb
      shift_q.raw <= {shift_q.raw[`SMU_FRAME_BITS-2:0], now_in.mosi};
      if (bit_count != '1)
        bit_count <= bit_count + 1'b1;
    end
  end

  // only exact length frames addressed to the fpga count
  assign frame_ok = cs_rise & ~now_in.special_n &
                    (bit_count == cnt_bits'(`SMU_FRAME_BITS));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      commit     <= 1'b0;
      soft_reset <= 1'b0;
    end
    else
    begin
      commit     <= frame_ok;
      soft_reset <= frame_ok && (shift_q.fields.addr == soft_reset_addr);
    end
  end

  // stable while commit is high, no shifting with cs_n up
  assign frame = shift_q;

endmodule

`default_nettype wire

// ==== source/ctl_reg_slice.sv ====
////////////////////////////////////////////////////////////////////////////
// control register slice
// one nibble register, set/clear/toggle at its own address
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctl_reg_slice #(
  parameter logic [7:0]            ADDR        = 8'd0,
  parameter smu_ctl_pkg::ctl_reg_t RESET_VALUE = '0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    commit,
  input  logic                    soft_reset,
  input  smu_spi_pkg::spi_frame_u frame,
  output smu_ctl_pkg::ctl_reg_t   value
);

  import smu_ctl_pkg::*;

  ctl_reg_t set_bits;
  ctl_reg_t clear_bits;
  ctl_reg_t toggle_bits;
  ctl_reg_t next_value;
  logic     hit;

  assign set_bits    = frame.fields.set;
  assign clear_bits  = frame.fields.clear;
  // same bit in both nibbles means flip it
  assign toggle_bits = set_bits & clear_bits;
  assign hit         = commit && (frame.fields.addr == ADDR);

  always_comb
  begin
    if (|toggle_bits)
      // toggle frame, the other bits hold
      next_value = value ^ toggle_bits;
    else
      // set first, then clear
      next_value = (value | set_bits) & ~clear_bits;
  end

  always_ff @(posedge clk)
  begin
    // soft reset wins, it comes with commit
    if (reset || soft_reset)
      value <= RESET_VALUE;
    else if (hit)
      value <= next_value;
  end

endmodule

`default_nettype wire

// ==== source/spi_route.sv ====
////////////////////////////////////////////////////////////////////////////
// spi routing and pin packing
// mux register steers cs_n and miso, registers map onto board pins
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "smu_ctl_settings.svh"

module spi_route (
  input  smu_ctl_pkg::ctl_regs_t       regs,
  input  logic                         cs_n,
  input  logic                         special_n,
  input  logic [`SMU_NUM_PERIPH-1:0]   miso_vec,
  output logic [`SMU_NUM_PERIPH-1:0]   cs_vec,
  output logic                         miso,
  output smu_ctl_pkg::smu_pins_t       pins
);

  import smu_ctl_pkg::*;

  ctl_reg_t                    mux;
  logic [`SMU_NUM_PERIPH-1:0]  sel;

  assign mux = regs[mux_index];
  // one bit per peripheral, more than one may be set
  assign sel = mux[`SMU_NUM_PERIPH-1:0];

  ////////////////////////////////////////////////////////////////////////
  // chip select and miso

  // special_n low means the fpga owns the bus, keep peripherals off it
  assign cs_vec = special_n ? ~(sel & {`SMU_NUM_PERIPH{~cs_n}}) : '1;

  // fpga itself has no readback, line held low
  assign miso = special_n & (|(sel & miso_vec));

  ////////////////////////////////////////////////////////////////////////
  // board pins

  always_comb
  begin
    pins = '0;

    // only two leds fitted
    pins.led = regs[led_index][1:0];

    pins.dac.ldac      = regs[dac_index][0];
    pins.dac.uni_bip_a = regs[dac_index][1];
    pins.dac.uni_bip_b = regs[dac_index][2];
    pins.dac.rst       = regs[dac_index][3];

    // lp5v, lp15v, lp30v, lp60v from bit 0 up
    pins.rails    = regs[rails_index];
    pins.rails_oe = regs[rails_oe_index][0];

    // a then b
    pins.dac_ref_mux = regs[dac_ref_mux_index][1:0];

    pins.adc.m0  = regs[adc_index][0];
    pins.adc.m1  = regs[adc_index][1];
    pins.adc.m2  = regs[adc_index][2];
    pins.adc.rst = regs[adc_index][3];

    // vset, iset, iset_inv, vset_inv
    pins.clamp1 = regs[clamp1_index];
    // min, inject_err, inject_vfb, max
    pins.clamp2 = regs[clamp2_index];
  end

endmodule

`default_nettype wire

// ==== source/smu_ctl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// smu control fpga top
// frame receiver, register slices and the spi router
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "smu_ctl_settings.svh"

module smu_ctl_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sclk,
  input  logic                        cs_n,
  input  logic                        special_n,
  input  logic                        mosi,
  input  logic [`SMU_NUM_PERIPH-1:0]  miso_vec,
  output logic [`SMU_NUM_PERIPH-1:0]  cs_vec,
  output logic                        miso,
  output smu_ctl_pkg::smu_pins_t      pins
);

  import smu_spi_pkg::*;
  import smu_ctl_pkg::*;

  spi_frame_u frame;
  logic       commit;
  logic       soft_reset;
  ctl_regs_t  regs;

  ////////////////////////////////////////////////////////////////////////
  // host frames in

  spi_frame_rx u_rx (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .special_n  (special_n),
    .mosi       (mosi),
    .frame      (frame),
    .commit     (commit),
    .soft_reset (soft_reset)
  );

  // one slice per mapped address
  for (genvar i = 0; i < `SMU_NUM_REGS; i++)
  begin : g_slice
    ctl_reg_slice #(
      .ADDR        (reg_addr_table[i]),
      .RESET_VALUE (reg_reset_table[i])
    ) u_slice (
      .clk        (clk),
      .reset      (reset),
      .commit     (commit),
      .soft_reset (soft_reset),
      .frame      (frame),
      .value      (regs[i])
    );
  end

  // routing and pins, no clock
  spi_route u_route (
    .regs      (regs),
    .cs_n      (cs_n),
    .special_n (special_n),
    .miso_vec  (miso_vec),
    .cs_vec    (cs_vec),
    .miso      (miso),
    .pins      (pins)
  );

endmodule

`default_nettype wire

// ==== verif/smu_ctl_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// smu control fpga testbench
// bit-bangs host spi frames from a table, checks pins against a model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "smu_ctl_settings.svh"

module smu_ctl_tb;

  import smu_ctl_pkg::*;

  // cs and miso expectations hold while cs_n is low
  typedef struct packed {
    logic        special_n;
    logic [31:0] word;
    logic [5:0]  nbits;
    logic [3:0]  miso_vec;
    logic [3:0]  exp_cs;
    logic        exp_miso;
  } row_t;

  localparam int num_rows     = 23;
  localparam int num_random   = 24;
  localparam int pins_timeout = 20;

  // led, mux, dac, rails, dac_ref_mux, adc, clamp1, clamp2, rails_oe
  localparam logic [7:0] model_addr [`SMU_NUM_REGS] = '{
    8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd16, 8'd24
  };
  localparam logic [3:0] model_reset [`SMU_NUM_REGS] = '{
    4'h0, 4'h0, 4'h0, 4'h0, 4'hf, 4'h0, 4'hf, 4'hf, 4'h1
  };

  ////////////////////////////////////////////////////////////////////////
  // stimulus table

  localparam row_t stim_table [num_rows] = '{
    '{1'b0, 32'h0703, 6'd16, 4'hf, 4'hf, 1'b0},
    // toggle, then overlap only on bit 0
    '{1'b0, 32'h0766, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0713, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h09a5, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0a05, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0c30, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0e09, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0fa0, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h1011, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h1810, 6'd16, 4'hf, 4'hf, 1'b0},
    // short, long, unmapped, pass-through frames
    '{1'b0, 32'h0703, 6'd15, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h0703, 6'd17, 4'hf, 4'hf, 1'b0},
    '{1'b0, 32'h050f, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b1, 32'h070f, 6'd16, 4'hf, 4'hf, 1'b0},
    // walk the mux one-hot
    '{1'b0, 32'h0801, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b1, 32'h070f, 6'd16, 4'h1, 4'he, 1'b1},
    '{1'b0, 32'h0812, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b1, 32'h070f, 6'd16, 4'hd, 4'hd, 1'b0},
    '{1'b0, 32'h0824, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b1, 32'h070f, 6'd16, 4'h4, 4'hb, 1'b1},
    '{1'b0, 32'h0848, 6'd16, 4'hf, 4'hf, 1'b0},
    '{1'b1, 32'h070f, 6'd16, 4'h8, 4'h7, 1'b1},
    // soft reset
    '{1'b0, 32'h0b00, 6'd16, 4'hf, 4'hf, 1'b0}
  };

  logic       clk;
  logic       reset;
  logic       sclk;
  logic       cs_n;
  logic       special_n;
  logic       mosi;
  logic [3:0] miso_vec;
  logic [3:0] cs_vec;
  logic       miso;
  smu_pins_t  pins;

  ctl_reg_t    model [`SMU_NUM_REGS];
  int          check_errors;
  int          timeout_errors;
  logic [31:0] lcg_state;
  row_t        rand_row;

  smu_ctl_top UUT (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .special_n (special_n),
    .mosi      (mosi),
    .miso_vec  (miso_vec),
    .cs_vec    (cs_vec),
    .miso      (miso),
    .pins      (pins)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // model

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // overlap toggles, otherwise set then clear
  function automatic ctl_reg_t update_value(input ctl_reg_t old, input ctl_reg_t clr,
                                            input ctl_reg_t set);
    if ((set & clr) != 4'h0)
      return old ^ (set & clr);
    return (old | set) & ~clr;
  endfunction

  function automatic smu_pins_t expected_pins();
    smu_pins_t p;
    p = '0;
    p.led           = model[0][1:0];
    p.dac.ldac      = model[2][0];
    p.dac.uni_bip_a = model[2][1];
    p.dac.uni_bip_b = model[2][2];
    p.dac.rst       = model[2][3];
    p.rails         = model[3];
    p.dac_ref_mux   = model[4][1:0];
    p.adc.m0        = model[5][0];
    p.adc.m1        = model[5][1];
    p.adc.m2        = model[5][2];
    p.adc.rst       = model[5][3];
    p.clamp1        = model[6];
    p.clamp2        = model[7];
    p.rails_oe      = model[8][0];
    return p;
  endfunction

  task automatic model_apply(input row_t r);
    // only exact frames with special_n low reach the registers
    if (!r.special_n && r.nbits == 6'd16)
    begin
      for (int i = 0; i < `SMU_NUM_REGS; i++)
      begin
        if (r.word[15:8] == 8'd11)
          model[i] = model_reset[i];
        else if (r.word[15:8] == model_addr[i])
          model[i] = update_value(model[i], r.word[7:4], r.word[3:0]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_pins(input string what, input smu_pins_t got, input smu_pins_t exp);
    if (got !== exp)
    begin
      check_errors++;
      $display("CHECK FAILED %s pins: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_cs(input string what, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
    begin
      check_errors++;
      $display("CHECK FAILED %s cs_vec: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_miso(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      check_errors++;
      $display("CHECK FAILED %s miso: got %h expected %h", what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // drivers

  task automatic drive_slot(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_pins(input string what);
    int n;
    n = 0;
    while (pins !== expected_pins() && n < pins_timeout)
    begin
      @(negedge clk);
      n++;
    end
    if (pins !== expected_pins())
    begin
      timeout_errors++;
      $display("%s: pins did not reach the model value within %0d cycles", what, n);
    end
  endtask

  // each sclk phase held 5 clk cycles, msb first
  task automatic apply_row(input row_t r, input string what);
    drive_slot(1);
    special_n = r.special_n;
    miso_vec  = r.miso_vec;
    drive_slot(4);
    cs_n = 1'b0;
    drive_slot(2);
    @(negedge clk);
    check_cs(what, cs_vec, r.exp_cs);
    check_miso(what, miso, r.exp_miso);
    drive_slot(1);
    for (int i = int'(r.nbits) - 1; i >= 0; i--)
    begin
      mosi = r.word[i];
      sclk = 1'b0;
      drive_slot(5);
      sclk = 1'b1;
      drive_slot(5);
    end
    sclk = 1'b0;
    drive_slot(5);
    cs_n = 1'b1;
    model_apply(r);
    @(negedge clk);
    check_cs(what, cs_vec, 4'hf);
    wait_pins(what);
    // pins must also stay put once settled
    drive_slot(6);
    @(negedge clk);
    check_pins(what, pins, expected_pins());
  endtask

  ////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    clk            = 1'b0;
    reset          = 1'b1;
    sclk           = 1'b0;
    cs_n           = 1'b1;
    special_n      = 1'b1;
    mosi           = 1'b0;
    miso_vec       = 4'h0;
    check_errors   = 0;
    timeout_errors = 0;
    lcg_state      = 32'h1464_3c6a;
    for (int i = 0; i < `SMU_NUM_REGS; i++)
      model[i] = model_reset[i];

    drive_slot(4);
    reset = 1'b0;
    @(negedge clk);
    check_pins("after reset", pins, expected_pins());
    check_cs("after reset", cs_vec, 4'hf);
    check_miso("after reset", miso, 1'b0);

    for (int i = 0; i < num_rows; i++)
      apply_row(stim_table[i], $sformatf("row %0d", i));

    // random set/clear nibbles to mapped addresses
    for (int k = 0; k < num_random; k++)
    begin
      lcg_state = lcg_next(lcg_state);
      rand_row  = '{1'b0, 32'h0, 6'd16, lcg_state[15:12], 4'hf, 1'b0};
      rand_row.word[15:8] = model_addr[int'(lcg_state[31:24]) % `SMU_NUM_REGS];
      rand_row.word[7:0]  = lcg_state[23:16];
      apply_row(rand_row, $sformatf("random %0d", k));
    end

    rand_row = '{1'b0, 32'h0b00, 6'd16, 4'hf, 4'hf, 1'b0};
    apply_row(rand_row, "final soft reset");

    $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== smu_ctl.f ====
+incdir+source
source/smu_spi_pkg.sv
source/smu_ctl_pkg.sv
source/spi_frame_rx.sv
source/ctl_reg_slice.sv
source/spi_route.sv
source/smu_ctl_top.sv
verif/smu_ctl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the SMU control testbench with Verilator, run it, and check the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
  echo "cannot create $build_dir"
  exit 1
fi

verilator --binary --timing --top-module smu_ctl_tb \
  -f smu_ctl.f --Mdir "$build_dir/obj" -o smu_ctl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$build_dir/obj/smu_ctl_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$log_file"; then
  exit 1
fi
exit 0
